//--- verilog/duckHuntPkg.sv
package duckHuntPkg;

	typedef enum logic [3:0] {Idle, Menu, Intro, Launch, Fly, Bounce, FlyOff, Hit, Fall,
		Retrieve, EndRound, GameOver, NewRound} gameStateT;
	typedef enum logic [2:0] {NW, W, NE, E, SW, SE} directionT;
	typedef enum logic [1:0] {Black, Red, Pink} duckColorT;
	typedef logic signed [10:0] coordT;	// Screen pixel, may go negative
	typedef logic [5:0] frameT;	// Duck sprite ROM index

	//////////////////////////////////////////////////////////////////////
	// Screen bounds and flight steps
	//////////////////////////////////////////////////////////////////////
	localparam coordT LaunchY = 11'sd236;	// Grass line
	localparam coordT MaxX = 11'sd576;
	localparam coordT MinEdge = 11'sd0;
	localparam coordT BounceNear = 11'sd20;
	localparam coordT BounceFarX = 11'sd556;
	localparam coordT BounceLowY = 11'sd216;
	localparam coordT FallStep = 11'sd10;
	localparam coordT FallEndY = 11'sd300;	// Below the grass
	localparam coordT StepLargeX = 11'sd15;
	localparam coordT StepSmallX = 11'sd12;
	localparam coordT StepLargeY = 11'sd10;
	localparam coordT StepSmallY = 11'sd2;

	localparam frameT ColorFrameOffset = 6'd20;	// One sprite bank per colour

	//////////////////////////////////////////////////////////////////////
	// Timing in animation ticks
	//////////////////////////////////////////////////////////////////////
	localparam logic [5:0] FlyAwayWarn = 6'd50;
	localparam logic [5:0] FlyAwayLimit = 6'd60;
	localparam logic [4:0] IntroTicks = 5'd8;
	localparam logic [4:0] ShockTicks = 5'd16;
	localparam logic [4:0] FlyOffTicks = 5'd4;
	localparam logic [4:0] RetrieveTicks = 5'd15;
	localparam logic [4:0] GameOverTicks = 5'd11;
	localparam logic [4:0] NewRoundTicks = 5'd6;
	localparam logic [1:0] ShotLimit = 2'd3;
	localparam logic [3:0] DucksPerRound = 4'd10;

	function automatic directionT foldDirection(input logic [2:0] raw);
		return (raw > 3'd5) ? NW : directionT'(raw);
	endfunction

	function automatic duckColorT foldColor(input logic [1:0] raw);
		return (raw == 2'd3) ? Black : duckColorT'(raw);
	endfunction

	function automatic logic isWest(input directionT dir);
		return (dir == NW) || (dir == W) || (dir == SW);
	endfunction

	function automatic frameT flyFrameBase(input directionT dir);
		case (dir)
			NW, SW: return 6'd11;
			W: return 6'd15;
			E: return 6'd4;
			default: return 6'd0;	// NE and SE share a sheet
		endcase
	endfunction

	function automatic frameT hitFrameBase(input directionT dir);
		return isWest(dir) ? 6'd19 : 6'd8;
	endfunction

	// Fall sprites are not evenly spaced across the colour banks
	function automatic frameT fallFrame(input directionT dir, input duckColorT color);
		frameT base;
		base = isWest(dir) ? 6'd10 : 6'd9;
		case (color)
			Red: return base + (isWest(dir) ? 6'd19 : 6'd21);
			Pink: return base + 6'd40;
			default: return base;
		endcase
	endfunction

	function automatic logic [3:0] killThreshold(input logic [7:0] roundNum);
		if (roundNum < 8'd11)
			return 4'd6;
		else if (roundNum < 8'd13)
			return 4'd7;
		else if (roundNum < 8'd15)
			return 4'd8;
		else if (roundNum < 8'd20)
			return 4'd9;
		return 4'd10;
	endfunction

endpackage

//--- verilog/roundSequencer.sv
`timescale 1ns/1ps

module roundSequencer
(
	input logic ANIM_Clk,
	input logic Reset,
	input logic Run,
	input logic startGame,
	input logic duckKill,
	input logic [1:0] shotCount,
	input logic atEdge,
	input logic fallDone,
	input logic roundDone,
	input logic roundFailed,
	output logic launch,
	output logic flyStep,
	output logic bounceStep,
	output logic hitStart,
	output logic fallStep,
	output logic newRound,
	output logic clearGame,
	output logic shootEnable,
	output logic flyAway,
	output logic outOfShots,
	output logic gameOver
);

	duckHuntPkg::gameStateT state, nextState;
	logic [4:0] phaseCnt;	// Ticks spent in current state
	logic [5:0] flyTimer;
	logic shotLatch;
	logic timeUp;
	logic flyEnd;	// Duck leaves Fly this tick

	assign timeUp = (flyTimer >= duckHuntPkg::FlyAwayLimit);
	assign flyEnd = shotLatch || timeUp || duckKill || atEdge;

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= duckHuntPkg::Idle;
			phaseCnt <= '0;
		end
		else
		begin
			state <= nextState;
			if (nextState != state)
				phaseCnt <= '0;	// Restart on every entry
			else
				phaseCnt <= phaseCnt + 5'd1;
		end
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			flyTimer <= '0;
			shotLatch <= 1'b0;
		end
		else if (state == duckHuntPkg::Launch)
		begin
			flyTimer <= '0;
			shotLatch <= 1'b0;
		end
		else
		begin
			if (shootEnable)
				flyTimer <= flyTimer + 6'd1;	// Bounce ticks count too
			if ((state == duckHuntPkg::Fly) && (shotCount == duckHuntPkg::ShotLimit))
				shotLatch <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		nextState = state;
		case (state)
			duckHuntPkg::Idle:
				if (Run)
					nextState = duckHuntPkg::Menu;
			duckHuntPkg::Menu:
				if (startGame)
					nextState = duckHuntPkg::Intro;
			duckHuntPkg::Intro:
				if (phaseCnt == duckHuntPkg::IntroTicks - 5'd1)
					nextState = duckHuntPkg::Launch;
			duckHuntPkg::Launch:
				nextState = duckHuntPkg::Fly;
			duckHuntPkg::Fly:
				if (shotLatch)
					nextState = duckHuntPkg::Retrieve;
				else if (timeUp)
					nextState = duckHuntPkg::FlyOff;
				else if (duckKill)
					nextState = duckHuntPkg::Hit;
				else if (atEdge)
					nextState = duckHuntPkg::Bounce;
			duckHuntPkg::Bounce:
				nextState = duckHuntPkg::Fly;
			duckHuntPkg::Hit:
				if (phaseCnt == duckHuntPkg::ShockTicks - 5'd1)
					nextState = duckHuntPkg::Fall;
			duckHuntPkg::Fall:
				if (fallDone)
					nextState = duckHuntPkg::Retrieve;
			duckHuntPkg::FlyOff:
				if (phaseCnt == duckHuntPkg::FlyOffTicks - 5'd1)
					nextState = duckHuntPkg::Retrieve;
			duckHuntPkg::Retrieve:	// Dog pause after every duck
				if (phaseCnt == duckHuntPkg::RetrieveTicks - 5'd1)
					nextState = roundDone ? duckHuntPkg::EndRound : duckHuntPkg::Launch;
			duckHuntPkg::EndRound:
				nextState = roundFailed ? duckHuntPkg::GameOver : duckHuntPkg::NewRound;
			duckHuntPkg::GameOver:
				if (phaseCnt == duckHuntPkg::GameOverTicks - 5'd1)
					nextState = duckHuntPkg::Menu;
			duckHuntPkg::NewRound:
				if (phaseCnt == duckHuntPkg::NewRoundTicks - 5'd1)
					nextState = duckHuntPkg::Intro;
			default:
				nextState = duckHuntPkg::Idle;
		endcase
	end

	assign launch = (state == duckHuntPkg::Launch);
	assign flyStep = (state == duckHuntPkg::Fly) && !flyEnd;
	assign bounceStep = (state == duckHuntPkg::Bounce);
	assign hitStart = (state == duckHuntPkg::Hit) && (phaseCnt == 5'd0);
	assign fallStep = (state == duckHuntPkg::Fall);
	assign newRound = (state == duckHuntPkg::NewRound) && (phaseCnt == 5'd0);
	assign clearGame = (state == duckHuntPkg::Menu);
	assign shootEnable = (state == duckHuntPkg::Fly) || (state == duckHuntPkg::Bounce);
	assign flyAway = shootEnable && (flyTimer >= duckHuntPkg::FlyAwayWarn) && !timeUp;
	assign outOfShots = shootEnable && shotLatch;	// Only shown while the duck is up
	assign gameOver = (state == duckHuntPkg::GameOver);

endmodule

//--- verilog/duckFlight.sv
`timescale 1ns/1ps

module duckFlight
(
	input logic ANIM_Clk,
	input logic Reset,
	input logic launch,
	input logic flyStep,
	input logic bounceStep,
	input logic fallStep,
	input logic [2:0] duckDirectionRand,
	input duckHuntPkg::coordT duckStartX,
	output duckHuntPkg::coordT duckX,
	output duckHuntPkg::coordT duckY,
	output duckHuntPkg::directionT direction,
	output logic atEdge,
	output logic fallDone
);

	duckHuntPkg::coordT stepX, stepY;
	duckHuntPkg::directionT bounceDir;
	logic headingWest, headingDown;
	logic atTop, atBottom, atLeft, atRight;

	always_comb
	begin
		case (direction)
			duckHuntPkg::NW:
			begin
				stepX = -duckHuntPkg::StepSmallX;
				stepY = -duckHuntPkg::StepLargeY;
			end
			duckHuntPkg::W:
			begin
				stepX = -duckHuntPkg::StepLargeX;
				stepY = -duckHuntPkg::StepSmallY;	// Level flight climbs slowly
			end
			duckHuntPkg::NE:
			begin
				stepX = duckHuntPkg::StepSmallX;
				stepY = -duckHuntPkg::StepLargeY;
			end
			duckHuntPkg::E:
			begin
				stepX = duckHuntPkg::StepLargeX;
				stepY = -duckHuntPkg::StepSmallY;
			end
			duckHuntPkg::SW:
			begin
				stepX = -duckHuntPkg::StepSmallX;
				stepY = duckHuntPkg::StepLargeY;
			end
			default:
			begin
				stepX = duckHuntPkg::StepSmallX;	// SE
				stepY = duckHuntPkg::StepLargeY;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Edges only count in the direction of travel
	//////////////////////////////////////////////////////////////////////
	assign headingWest = duckHuntPkg::isWest(direction);
	assign headingDown = (direction == duckHuntPkg::SW) || (direction == duckHuntPkg::SE);
	assign atTop = !headingDown && (duckY <= duckHuntPkg::MinEdge);
	assign atBottom = headingDown && (duckY >= duckHuntPkg::LaunchY);	// Grass line
	assign atLeft = headingWest && (duckX <= duckHuntPkg::MinEdge);
	assign atRight = !headingWest && (duckX >= duckHuntPkg::MaxX);
	assign atEdge = atTop || atBottom || atLeft || atRight;
	assign fallDone = (duckY > duckHuntPkg::FallEndY);

	always_comb
	begin
		if (atTop)
			bounceDir = headingWest ? duckHuntPkg::SW : duckHuntPkg::SE;
		else if (atBottom)
			bounceDir = (direction == duckHuntPkg::SW) ? duckHuntPkg::NW : duckHuntPkg::NE;
		else
		begin
			case (direction)	// Side walls swap east and west
				duckHuntPkg::NW:
					bounceDir = duckHuntPkg::NE;
				duckHuntPkg::W:
					bounceDir = duckHuntPkg::E;
				duckHuntPkg::NE:
					bounceDir = duckHuntPkg::NW;
				duckHuntPkg::E:
					bounceDir = duckHuntPkg::W;
				duckHuntPkg::SW:
					bounceDir = duckHuntPkg::SE;
				default:
					bounceDir = duckHuntPkg::SW;
			endcase
		end
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			duckX <= '0;
			duckY <= '0;
			direction <= duckHuntPkg::NW;
		end
		else if (launch)
		begin
			duckX <= duckStartX;
			duckY <= duckHuntPkg::LaunchY;
			direction <= duckHuntPkg::foldDirection(duckDirectionRand);
		end
		else if (flyStep)
		begin
			duckX <= duckX + stepX;
			duckY <= duckY + stepY;
		end
		else if (bounceStep)
		begin
			direction <= bounceDir;
			if (atTop)
				duckY <= duckHuntPkg::BounceNear;
			else if (atBottom)
				duckY <= duckHuntPkg::BounceLowY;
			else if (atLeft)
				duckX <= duckHuntPkg::BounceNear;
			else if (atRight)
				duckX <= duckHuntPkg::BounceFarX;
		end
		else if (fallStep)
			duckY <= duckY + duckHuntPkg::FallStep;
	end

endmodule

//--- verilog/duckSprite.sv
`timescale 1ns/1ps

module duckSprite
(
	input logic ANIM_Clk,
	input logic Reset,
	input logic launch,
	input logic flyStep,
	input logic bounceStep,
	input logic hitStart,
	input logic fallStep,
	input duckHuntPkg::directionT direction,
	input logic [1:0] duckColorRand,
	output duckHuntPkg::frameT duckFrame
);

	typedef enum logic [1:0] {ShowFly, ShowHit, ShowFall} spriteModeT;

	spriteModeT mode;
	logic [1:0] wing;	// Wing flap phase
	duckHuntPkg::duckColorT color;
	duckHuntPkg::frameT colorOffset;

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			mode <= ShowFly;
			wing <= 2'd0;
		end
		else if (launch || bounceStep)
		begin
			mode <= ShowFly;
			wing <= 2'd0;	// Back to base frame
		end
		else if (flyStep)
			wing <= wing + 2'd1;
		else if (hitStart)
			mode <= ShowHit;
		else if (fallStep)
			mode <= ShowFall;
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
			color <= duckHuntPkg::Black;
		else if (launch)
			color <= duckHuntPkg::foldColor(duckColorRand);
	end

	assign colorOffset = duckHuntPkg::ColorFrameOffset * duckHuntPkg::frameT'(color);

	always_comb
	begin
		case (mode)
			ShowHit:
				duckFrame = duckHuntPkg::hitFrameBase(direction) + colorOffset;
			ShowFall:
				duckFrame = duckHuntPkg::fallFrame(direction, color);
			default:
				duckFrame = duckHuntPkg::flyFrameBase(direction) + colorOffset
					+ duckHuntPkg::frameT'(wing);
		endcase
	end

endmodule

//--- verilog/roundScore.sv
`timescale 1ns/1ps

module roundScore
(
	input logic ANIM_Clk,
	input logic Reset,
	input logic launch,
	input logic hitStart,
	input logic newRound,
	input logic clearGame,
	output logic [9:0] duckKilled,
	output logic [7:0] roundNumber,
	output logic roundDone,
	output logic roundFailed
);

	logic [3:0] duckCount;	// Ducks launched this round
	logic [3:0] killTotal;

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			duckCount <= 4'd0;
			killTotal <= 4'd0;
			duckKilled <= 10'd0;
			roundNumber <= 8'd1;
		end
		else if (clearGame || newRound)
		begin
			duckCount <= 4'd0;
			killTotal <= 4'd0;
			duckKilled <= 10'd0;
			if (clearGame)
				roundNumber <= 8'd1;	// Fresh game from the menu
			else
				roundNumber <= roundNumber + 8'd1;
		end
		else
		begin
			if (launch)
				duckCount <= duckCount + 4'd1;
			if (hitStart)
			begin
				duckKilled <= duckKilled | (10'd1 << (duckCount - 4'd1));	// Current duck
				killTotal <= killTotal + 4'd1;
			end
		end
	end

	assign roundDone = (duckCount >= duckHuntPkg::DucksPerRound);
	assign roundFailed = (killTotal < duckHuntPkg::killThreshold(roundNumber));

endmodule

//--- verilog/duckHuntTop.sv
`timescale 1ns/1ps

module duckHuntTop
(
	input logic ANIM_Clk,
	input logic Reset,
	input logic Run,
	input logic startGame,
	input logic duckKill,
	input logic [1:0] shotCount,
	input logic [1:0] duckColorRand,
	input logic [2:0] duckDirectionRand,
	input duckHuntPkg::coordT duckStartX,
	output duckHuntPkg::coordT duckX,
	output duckHuntPkg::coordT duckY,
	output duckHuntPkg::frameT duckFrame,
	output logic [9:0] duckKilled,
	output logic [7:0] roundNumber,
	output logic shootEnable,
	output logic flyAway,
	output logic outOfShots,
	output logic gameOver
);

	logic launch, flyStep, bounceStep, hitStart, fallStep;	// Sequencer strobes
	logic newRound, clearGame;
	logic atEdge, fallDone, roundDone, roundFailed;
	duckHuntPkg::directionT direction;

	roundSequencer sequencer (.ANIM_Clk(ANIM_Clk), .Reset(Reset), .Run(Run),
		.startGame(startGame), .duckKill(duckKill), .shotCount(shotCount), .atEdge(atEdge),
		.fallDone(fallDone), .roundDone(roundDone), .roundFailed(roundFailed),
		.launch(launch), .flyStep(flyStep), .bounceStep(bounceStep), .hitStart(hitStart),
		.fallStep(fallStep), .newRound(newRound), .clearGame(clearGame),
		.shootEnable(shootEnable), .flyAway(flyAway), .outOfShots(outOfShots),
		.gameOver(gameOver));

	duckFlight flight (.ANIM_Clk(ANIM_Clk), .Reset(Reset), .launch(launch),
		.flyStep(flyStep), .bounceStep(bounceStep), .fallStep(fallStep),
		.duckDirectionRand(duckDirectionRand), .duckStartX(duckStartX), .duckX(duckX),
		.duckY(duckY), .direction(direction), .atEdge(atEdge), .fallDone(fallDone));

	duckSprite sprite (.ANIM_Clk(ANIM_Clk), .Reset(Reset), .launch(launch),
		.flyStep(flyStep), .bounceStep(bounceStep), .hitStart(hitStart),
		.fallStep(fallStep), .direction(direction), .duckColorRand(duckColorRand),
		.duckFrame(duckFrame));

	roundScore score (.ANIM_Clk(ANIM_Clk), .Reset(Reset), .launch(launch),
		.hitStart(hitStart), .newRound(newRound), .clearGame(clearGame),
		.duckKilled(duckKilled), .roundNumber(roundNumber), .roundDone(roundDone),
		.roundFailed(roundFailed));

endmodule

//--- tb/duckHunt_assertions.sv
`timescale 1ns/1ps

module duckHuntAssertions
(
	input logic ANIM_Clk,
	input logic Reset,
	input logic shootEnable,
	input logic flyAway,
	input logic outOfShots,
	input logic gameOver,
	input logic [9:0] duckKilled,
	input logic [7:0] roundNumber
);

	// Timer and shot latch start clear for every duck
	newDuckClear: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		$rose(shootEnable) |-> !flyAway && !outOfShots)
		else $error("flyAway or outOfShots already high as a duck appears");

	flyAwayEndsDuck: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		$fell(flyAway) && shootEnable |-> ##2 !shootEnable)
		else $error("duck still up after the fly-away warning ended");

	noShotsEndsDuck: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		outOfShots |-> ##2 !shootEnable)
		else $error("duck still up after outOfShots was raised");

	failedRoundOnly: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		$rose(gameOver) && (roundNumber < 8'd11) |-> $countones(duckKilled) < 6)
		else $error("gameOver raised in an early round with six or more kills");

endmodule

bind duckHuntTop duckHuntAssertions outputChecks (.ANIM_Clk(ANIM_Clk), .Reset(Reset),
	.shootEnable(shootEnable), .flyAway(flyAway), .outOfShots(outOfShots),
	.gameOver(gameOver), .duckKilled(duckKilled), .roundNumber(roundNumber));

//--- tb/duckHuntTb.sv
`timescale 1ns/1ps

module duckHuntTb;

	logic ANIM_Clk, Reset, Run, startGame, duckKill;
	logic [1:0] shotCount, duckColorRand;
	logic [2:0] duckDirectionRand;
	duckHuntPkg::coordT duckStartX, duckX, duckY;
	duckHuntPkg::frameT duckFrame;
	logic [9:0] duckKilled, expectedMask;
	logic [7:0] roundNumber;
	logic shootEnable, flyAway, outOfShots, gameOver;
	logic [31:0] lfsrState;
	int valueErrors, otherErrors;

	typedef enum logic [1:0] {Shoot, FlyAway, NoShots} actionT;
	typedef enum logic [1:0] {ShootUp, GameOverUp, GameOverDown, SecondRound} waitT;

	// Rows 0 to 4 fill the failed round, rows 5 to 9 the passed one
	logic [1:0] rowColor [10] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd0, 2'd1, 2'd0, 2'd2};
	logic [2:0] rowDir [10] = '{3'd2, 3'd1, 3'd0, 3'd5, 3'd7, 3'd3, 3'd4, 3'd1, 3'd0, 3'd2};
	int rowX [10] = '{100, 30, 300, 400, 40, 560, 200, 250, 500, 150};
	actionT rowAction [10] = '{Shoot, FlyAway, NoShots, FlyAway, Shoot,
		Shoot, Shoot, NoShots, Shoot, FlyAway};
	int rowTicks [10] = '{5, 0, 4, 0, 6, 4, 3, 2, 8, 0};	// Flight ticks before acting
	logic rowKill [10] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};

	duckHuntTop uut (.*);

	initial
	begin
		ANIM_Clk = 1'b0;
		forever #50 ANIM_Clk = ~ANIM_Clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model of flight and sprites
	//////////////////////////////////////////////////////////////////////
	// Headings 0 to 5 are NW, W, NE, E, SW, SE
	function automatic int flyBase(input int dir);
		case (dir)
			0, 4: return 11;
			1: return 15;
			3: return 4;
			default: return 0;
		endcase
	endfunction

	function automatic int stepXOf(input int dir);
		case (dir)
			0, 4: return -12;
			1: return -15;
			3: return 15;
			default: return 12;
		endcase
	endfunction

	function automatic int stepYOf(input int dir);
		if (dir >= 4)
			return 10;
		return (dir == 1 || dir == 3) ? -2 : -10;	// Level flight climbs slowly
	endfunction

	function automatic logic isWest(input int dir);
		return (dir == 0) || (dir == 1) || (dir == 4);
	endfunction

	function automatic int mirror(input int dir);
		case (dir)
			0: return 2;
			1: return 3;
			2: return 0;
			3: return 1;
			4: return 5;
			default: return 4;
		endcase
	endfunction

	task automatic reflect(input int px, input int py, inout int dir, output int ex, output int ey);
		ex = px;
		ey = py;
		if (dir < 4 && py <= 0)
		begin
			dir = isWest(dir) ? 4 : 5;	// Top turns it downward
			ey = 20;
		end
		else if (dir >= 4 && py >= 236)
		begin
			dir = (dir == 4) ? 0 : 2;
			ey = 216;
		end
		else if (isWest(dir) && px <= 0)
		begin
			dir = mirror(dir);
			ex = 20;
		end
		else if (!isWest(dir) && px >= 576)
		begin
			dir = mirror(dir);
			ex = 556;
		end
		else
		begin
			$display("Duck stopped at (%0d, %0d) away from every screen edge", px, py);
			otherErrors++;
		end
	endtask

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32, 22, 2, 1
	endfunction

	task automatic randomBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks and waits
	//////////////////////////////////////////////////////////////////////
	task automatic checkValue(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("ERR %0t %s: got %0d, expected %0d", $time, name, actual, expected);
			valueErrors++;
		end
	endtask

	task automatic failTimeout(input string what);
		$display("Timed out waiting for %s", what);
		otherErrors++;
		$display("%0d value errors, %0d other errors", valueErrors, otherErrors);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic nextTick();
		@(posedge ANIM_Clk);
		#5;	// Sample and drive slot
	endtask

	function automatic logic waitDone(input waitT kind);
		case (kind)
			ShootUp: return shootEnable;
			GameOverUp: return gameOver;
			GameOverDown: return !gameOver;
			default: return roundNumber == 8'd2;
		endcase
	endfunction

	task automatic waitFor(input waitT kind, input int limit, input string what);
		int n;
		n = 0;
		while (!waitDone(kind))
		begin
			if (n == limit)
				failTimeout(what);
			nextTick();
			n++;
		end
	endtask

	task automatic takeAction(input actionT action, input int ticks, input int actTicks);
		if (action == Shoot && ticks >= actTicks)
			duckKill = 1'b1;	// Held until the hit is taken
		if (action == NoShots && ticks >= actTicks)
			shotCount = 2'd3;
	endtask

	task automatic flyDuck(input logic [1:0] colorRaw, input logic [2:0] dirRaw,
		input int startX, input actionT action, input int actTicks, input logic kill,
		input int idx);
		int dir, color, x, y, px, py, ex, ey, wing, ticks, n;
		logic flying, bounced, seenWarn, seenNoShots;
		duckColorRand = colorRaw;
		duckDirectionRand = dirRaw;
		duckStartX = duckHuntPkg::coordT'(startX);
		dir = (dirRaw > 3'd5) ? 0 : int'(dirRaw);
		color = (colorRaw == 2'd3) ? 0 : int'(colorRaw);
		waitFor(ShootUp, 300, "a duck launch");
		px = int'(duckX);
		py = int'(duckY);
		checkValue("duckX", px, startX);
		checkValue("duckY", py, 236);
		checkValue("duckFrame", int'(duckFrame), flyBase(dir) + 20 * color);
		wing = 0;
		ticks = 1;
		n = 0;
		flying = 1'b1;
		bounced = 1'b0;
		seenWarn = flyAway;
		seenNoShots = outOfShots;
		takeAction(action, ticks, actTicks);
		while (flying)
		begin
			if (n == 200)
				failTimeout("the duck to leave the sky");
			nextTick();
			n++;
			if (!shootEnable)
				flying = 1'b0;
			else
			begin
				x = int'(duckX);
				y = int'(duckY);
				seenWarn |= flyAway;
				seenNoShots |= outOfShots;
				if (x < -15 || x > 591 || y < -10 || y > 246)
				begin
					$display("Duck %0d went more than a step past an edge at (%0d, %0d)",
						idx, x, y);
					otherErrors++;
				end
				if (bounced)
				begin
					checkValue("duckX", x, ex);	// Clamped after the bounce
					checkValue("duckY", y, ey);
					wing = 0;
					checkValue("duckFrame", int'(duckFrame), flyBase(dir) + 20 * color);
					bounced = 1'b0;
				end
				else if (x == px && y == py)
				begin
					reflect(px, py, dir, ex, ey);	// Bounce tick holds the position
					bounced = 1'b1;
				end
				else
				begin
					checkValue("duckX", x, px + stepXOf(dir));
					checkValue("duckY", y, py + stepYOf(dir));
					wing = (wing + 1) % 4;
					checkValue("duckFrame", int'(duckFrame), flyBase(dir) + 20 * color + wing);
				end
				px = x;
				py = y;
				ticks++;
				takeAction(action, ticks, actTicks);
			end
		end
		duckKill = 1'b0;
		shotCount = 2'd0;
		if (action == FlyAway && !seenWarn)
		begin
			$display("Duck %0d flew off without flyAway rising", idx);
			otherErrors++;
		end
		if (action == NoShots && !seenNoShots)
		begin
			$display("Duck %0d ended without outOfShots rising", idx);
			otherErrors++;
		end
		if (kill)
		begin
			expectedMask = expectedMask | (10'd1 << idx);
			nextTick();	// Kill bit lands after hitStart
			checkValue("duckKilled", int'(duckKilled), int'(expectedMask));
			py = int'(duckY);
			n = 0;
			while (py <= 300)
			begin
				if (n == 100)
					failTimeout("the shot duck to fall below the grass");
				nextTick();
				n++;
				y = int'(duckY);
				if (y != py && y != py + 10)
				begin
					$display("ERR %0t duckY: got %0d, expected %0d", $time, y, py + 10);
					valueErrors++;
				end
				py = y;
			end
		end
		else
			checkValue("duckKilled", int'(duckKilled), int'(expectedMask));
	endtask

	initial
	begin
		int rc, rd, row;
		Reset = 1'b1;
		Run = 1'b0;
		startGame = 1'b0;
		duckKill = 1'b0;
		shotCount = 2'd0;
		duckColorRand = 2'd0;
		duckDirectionRand = 3'd0;
		duckStartX = '0;
		lfsrState = 32'h35d;
		valueErrors = 0;
		otherErrors = 0;
		expectedMask = '0;
		repeat (8) @(posedge ANIM_Clk);
		#5;
		checkValue("shootEnable", int'(shootEnable), 0);
		checkValue("flyAway", int'(flyAway), 0);
		checkValue("outOfShots", int'(outOfShots), 0);
		checkValue("gameOver", int'(gameOver), 0);
		checkValue("roundNumber", int'(roundNumber), 1);
		checkValue("duckKilled", int'(duckKilled), 0);
		Reset = 1'b0;
		for (int game = 0; game < 2; game++)
		begin
			expectedMask = '0;
			Run = 1'b1;
			startGame = 1'b1;	// Idle to Menu, then Menu to Intro
			nextTick();
			nextTick();
			startGame = 1'b0;
			for (int duck = 0; duck < 10; duck++)
			begin
				row = game * 5 + duck;
				if (duck < 5)
					flyDuck(rowColor[row], rowDir[row], rowX[row], rowAction[row],
						rowTicks[row], rowKill[row], duck);
				else
				begin
					randomBits(2, rc);
					randomBits(3, rd);
					if (game == 0)
						flyDuck(2'(rc), 3'(rd), 250, FlyAway, 0, 1'b0, duck);
					else
						flyDuck(2'(rc), 3'(rd), 250, Shoot, 3, 1'b1, duck);
				end
			end
			if (game == 0)
			begin
				waitFor(GameOverUp, 100, "gameOver after the failed round");
				waitFor(GameOverDown, 30, "the return to the menu");
				nextTick();
				checkValue("roundNumber", int'(roundNumber), 1);
				checkValue("duckKilled", int'(duckKilled), 0);
			end
			else
			begin
				waitFor(SecondRound, 100, "round 2 to begin");
				checkValue("duckKilled", int'(duckKilled), 0);
			end
		end
		$display("%0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- duckHunt.f
verilog/duckHuntPkg.sv
verilog/roundSequencer.sv
verilog/duckFlight.sv
verilog/duckSprite.sv
verilog/roundScore.sv
verilog/duckHuntTop.sv
tb/duckHunt_assertions.sv
tb/duckHuntTb.sv

//--- run.sh
#!/bin/sh
# Build and run the duckHunt testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module duckHuntTb -f duckHunt.f -o duckHuntSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi
./obj_dir/duckHuntSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi
exit 0
